//--- run_sim.sh
#!/bin/bash
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_core \
  -o tb_core_sim || { echo "Build failed"; exit 1; }
./obj_dir/tb_core_sim > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation did not pass"; exit 1; }
exit 0

//--- sources.f
+incdir+src
src/rv32_pkg.sv
src/mem_if.sv
src/control_unit.sv
src/exec_datapath.sv
src/fetch_sequencer.sv
src/load_store_unit.sv
src/mem_arbiter.sv
src/rv32_core.sv
test/core_asserts.sv
test/tb_core.sv

//--- src/control_unit.sv
// Instruction decoder
`timescale 1ns/1ps

module control_unit import rv32_pkg::*; (
  input  word_t    instr_i,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  output reg_idx_t rd_o,
  output word_t    imm_o,
  output alu_op_t  alu_op_o,
  output a_sel_t   a_sel_o,
  output b_sel_t   b_sel_o,
  output wb_sel_t  wb_sel_o,
  output logic     wen_o,
  output logic     dren_o,
  output logic     dwen_o,
  output logic     branch_o,
  output logic     jump_o,
  output logic     jalr_o,
  output logic     halt_o,
  output logic     illegal_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign rd_o  = instr_i[11:7];

  // Immediate format follows the opcode, I-type otherwise
  always_comb begin
    case (opcode)
      STORE:      imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      BRANCH:     imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                           instr_i[11:8], 1'b0};
      LUI, AUIPC: imm_o = {instr_i[31:12], 12'b0};
      JAL:        imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                           instr_i[30:21], 1'b0};
      default:    imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
    endcase
  end

  // Bit 30 picks SUB and SRA; for ADDI it belongs to the immediate
  always_comb begin
    alu_op_o = ALU_ADD;
    if (opcode == IMMED || opcode == REGREG) begin
      case (funct3)
        3'b000:  alu_op_o = (opcode == REGREG && instr_i[30]) ? ALU_SUB : ALU_ADD;
        3'b001:  alu_op_o = ALU_SLL;
        3'b010:  alu_op_o = ALU_SLT;
        3'b011:  alu_op_o = ALU_SLTU;
        3'b100:  alu_op_o = ALU_XOR;
        3'b101:  alu_op_o = instr_i[30] ? ALU_SRA : ALU_SRL;
        3'b110:  alu_op_o = ALU_OR;
        default: alu_op_o = ALU_AND;
      endcase
    end
  end

  assign a_sel_o = (opcode == AUIPC) ? A_PC : A_RS1;
  assign b_sel_o = (opcode == REGREG) ? B_RS2 : B_IMM;

  always_comb begin
    case (opcode)
      LOAD:      wb_sel_o = WB_LOAD;
      JAL, JALR: wb_sel_o = WB_PC_PLUS4;
      LUI:       wb_sel_o = WB_IMM_U;
      default:   wb_sel_o = WB_ALU;
    endcase
  end

  assign wen_o    = (opcode == LUI) || (opcode == AUIPC) || (opcode == JAL) ||
                    (opcode == JALR) || (opcode == LOAD) || (opcode == IMMED) ||
                    (opcode == REGREG);
  assign dren_o   = (opcode == LOAD);
  assign dwen_o   = (opcode == STORE);
  assign branch_o = (opcode == BRANCH);
  assign jump_o   = (opcode == JAL) || (opcode == JALR);
  assign jalr_o   = (opcode == JALR);

  // Jump to self ends the program
  assign halt_o = (instr_i == 32'h0000006f);

  always_comb begin
    case (opcode)
      LUI, AUIPC, JAL: illegal_o = 1'b0;
      IMMED:           illegal_o = 1'b0;
      JALR:            illegal_o = (funct3 != 3'b000);
      BRANCH:          illegal_o = (funct3 == 3'b010) || (funct3 == 3'b011);
      LOAD, STORE:     illegal_o = (funct3 != 3'b010);
      REGREG:          illegal_o = (funct7 & 7'b1011111) != 7'b0 ||
                                   (instr_i[30] && funct3 != 3'b000 && funct3 != 3'b101);
      default:         illegal_o = 1'b1;
    endcase
  end

endmodule

//--- src/core_cfg.svh
// Core build configuration
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Byte address width of the memory port
`define CORE_ADDR_W 16

// First instruction fetched after reset
`define CORE_RESET_PC 'h0000

`endif

//--- src/exec_datapath.sv
// Register file, ALU and next PC
`timescale 1ns/1ps

module exec_datapath import rv32_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  addr_t      pc_i,
  input  reg_idx_t   rs1_i,
  input  reg_idx_t   rs2_i,
  input  reg_idx_t   rd_i,
  input  word_t      imm_i,
  input  alu_op_t    alu_op_i,
  input  a_sel_t     a_sel_i,
  input  b_sel_t     b_sel_i,
  input  wb_sel_t    wb_sel_i,
  input  logic       branch_i,
  input  logic       jump_i,
  input  logic       jalr_i,
  input  logic [2:0] funct3_i,
  input  word_t      load_data_i,
  input  logic       wb_en_i,
  output addr_t      next_pc_o,
  output word_t      alu_result_o,
  output word_t      store_data_o
);

  word_t regs [1:31];
  word_t rs1_val, rs2_val, op_a, op_b, alu_result, wb_data, jalr_sum;
  addr_t pc_plus4;
  logic  taken;

  // x0 is not stored
  assign rs1_val = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rs2_val = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

  assign op_a = (a_sel_i == A_PC) ? word_t'(pc_i) : rs1_val;
  assign op_b = (b_sel_i == B_IMM) ? imm_i : rs2_val;

  always_comb begin
    case (alu_op_i)
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << op_b[4:0];
      ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> op_b[4:0];
      ALU_SRA:  alu_result = $signed(op_a) >>> op_b[4:0];
      ALU_AND:  alu_result = op_a & op_b;
      ALU_OR:   alu_result = op_a | op_b;
      default:  alu_result = op_a + op_b;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (funct3_i)
      3'b000:  taken = (rs1_val == rs2_val);
      3'b001:  taken = (rs1_val != rs2_val);
      3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  taken = (rs1_val < rs2_val);
      3'b111:  taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc_i + addr_t'(4);
  assign jalr_sum = rs1_val + imm_i;

  always_comb begin
    if (jalr_i) begin
      next_pc_o = addr_t'(jalr_sum) & ~addr_t'(1);
    end else if (jump_i || (branch_i && taken)) begin
      next_pc_o = pc_i + addr_t'(imm_i);
    end else begin
      next_pc_o = pc_plus4;
    end
  end

  always_comb begin
    case (wb_sel_i)
      WB_LOAD:     wb_data = load_data_i;
      WB_PC_PLUS4: wb_data = word_t'(pc_plus4);
      WB_IMM_U:    wb_data = imm_i;
      default:     wb_data = alu_result;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i && rd_i != 5'd0) begin
      regs[rd_i] <= wb_data;
    end
  end

  assign alu_result_o = alu_result;
  assign store_data_o = rs2_val;

endmodule

//--- src/fetch_sequencer.sv
// Fetch and retire sequencer
`timescale 1ns/1ps
`include "core_cfg.svh"

module fetch_sequencer import rv32_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  mem_if.requester        mem,
  output word_t           instr_o,
  output addr_t           pc_o,
  input  addr_t           next_pc_i,
  input  logic            wen_i,
  input  logic            dren_i,
  input  logic            dwen_i,
  input  logic            halt_i,
  input  logic            illegal_i,
  output logic            mem_start_o,
  input  logic            mem_done_i,
  output logic            wb_en_o,
  output logic            retire_o,
  output logic            halt_o,
  output logic            illegal_o
);

  seq_state_t state_q, state_d;
  addr_t      pc_q;
  word_t      ir_q;
  logic       halt_q, illegal_q;
  logic       started_q;
  logic       is_mem, stop;

  assign is_mem = dren_i | dwen_i;
  assign stop   = (state_q == EXECUTE) && (halt_i || illegal_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH:      if (started_q) state_d = FETCH_WAIT;
      FETCH_WAIT: if (mem.rvalid) state_d = EXECUTE;
      EXECUTE: begin
        if (halt_i || illegal_i) begin
          state_d = STOPPED;
        end else if (is_mem) begin
          state_d = MEM_WAIT;
        end else begin
          state_d = FETCH;
        end
      end
      MEM_WAIT:   if (mem_done_i) state_d = FETCH;
      default:    state_d = STOPPED;
    endcase
  end

  // Fetch port is read only, quiet for the first cycle out of reset
  assign mem.req   = (state_q == FETCH) && started_q;
  assign mem.we    = 1'b0;
  assign mem.addr  = pc_q;
  assign mem.wdata = '0;

  assign mem_start_o = (state_q == EXECUTE) && !stop && is_mem;
  assign retire_o    = ((state_q == EXECUTE) && !stop && !is_mem) ||
                       ((state_q == MEM_WAIT) && mem_done_i);
  assign wb_en_o     = retire_o && wen_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= FETCH;
      pc_q      <= `CORE_RESET_PC;
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
      started_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      started_q <= 1'b1;
      if (retire_o) begin
        pc_q <= next_pc_i;
      end
      // Sticky until reset
      if (stop) begin
        halt_q    <= halt_i;
        illegal_q <= illegal_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == FETCH_WAIT && mem.rvalid) begin
      ir_q <= mem.rdata;
    end
  end

  assign instr_o   = ir_q;
  assign pc_o      = pc_q;
  assign halt_o    = halt_q;
  assign illegal_o = illegal_q;

endmodule

//--- src/load_store_unit.sv
// Word load/store unit
`timescale 1ns/1ps

module load_store_unit import rv32_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     start_i,
  input  logic     we_i,
  input  addr_t    addr_i,
  input  word_t    wdata_i,
  mem_if.requester mem,
  output logic     done_o,
  output word_t    load_data_o
);

  logic  req_q, done_q, we_q;
  addr_t addr_q;
  word_t wdata_q, rdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      req_q  <= start_i;
      done_q <= mem.rvalid;
    end
  end

  // Request payload and returned data
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (mem.rvalid) begin
      rdata_q <= mem.rdata;
    end
  end

  assign mem.req     = req_q;
  assign mem.we      = we_q;
  assign mem.addr    = addr_q;
  assign mem.wdata   = wdata_q;
  assign done_o      = done_q;
  assign load_data_o = rdata_q;

endmodule

//--- src/mem_arbiter.sv
// Shared memory port arbiter
`timescale 1ns/1ps

module mem_arbiter import rv32_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  mem_if.arbiter fetch_port,
  mem_if.arbiter lsu_port,
  output logic   mem_req_o,
  output logic   mem_we_o,
  output addr_t  mem_addr_o,
  output word_t  mem_wdata_o,
  input  word_t  mem_rdata_i,
  input  logic   mem_rvalid_i
);

  logic lsu_sel;
  logic owner_valid_q, owner_lsu_q;

  // Load/store unit wins a same-cycle collision
  assign lsu_sel     = lsu_port.req;
  assign mem_req_o   = fetch_port.req | lsu_port.req;
  assign mem_we_o    = lsu_sel ? lsu_port.we : fetch_port.we;
  assign mem_addr_o  = lsu_sel ? lsu_port.addr : fetch_port.addr;
  assign mem_wdata_o = lsu_sel ? lsu_port.wdata : fetch_port.wdata;

  // Owner of the outstanding request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_valid_q <= 1'b0;
      owner_lsu_q   <= 1'b0;
    end else if (mem_req_o) begin
      owner_valid_q <= 1'b1;
      owner_lsu_q   <= lsu_sel;
    end else if (mem_rvalid_i) begin
      owner_valid_q <= 1'b0;
    end
  end

  assign fetch_port.rvalid = mem_rvalid_i && owner_valid_q && !owner_lsu_q;
  assign lsu_port.rvalid   = mem_rvalid_i && owner_valid_q && owner_lsu_q;
  assign fetch_port.rdata  = mem_rdata_i;
  assign lsu_port.rdata    = mem_rdata_i;

endmodule

//--- src/mem_if.sv
// Memory requester link
`timescale 1ns/1ps

interface mem_if import rv32_pkg::*; ();

  // Request side, a one-cycle strobe
  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;

  // Response side, rvalid strobes once per request
  word_t rdata;
  logic  rvalid;

  modport requester (
    output req, we, addr, wdata,
    input  rdata, rvalid
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output rdata, rvalid
  );

endinterface

//--- src/rv32_core.sv
// RV32I multi-cycle core
`timescale 1ns/1ps

module rv32_core import rv32_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  output logic  mem_req_o,
  output logic  mem_we_o,
  output addr_t mem_addr_o,
  output word_t mem_wdata_o,
  input  word_t mem_rdata_i,
  input  logic  mem_rvalid_i,
  output logic  retire_o,
  output logic  halt_o,
  output logic  illegal_o
);

  mem_if fetch_bus ();
  mem_if lsu_bus ();

  word_t    instr, imm, alu_result, store_data, load_data;
  addr_t    pc, next_pc;
  reg_idx_t rs1, rs2, rd;
  alu_op_t  alu_op;
  a_sel_t   a_sel;
  b_sel_t   b_sel;
  wb_sel_t  wb_sel;
  logic     wen, dren, dwen, branch, jump, jalr, dec_halt, dec_illegal;
  logic     mem_start, mem_done, wb_en;

  fetch_sequencer u_seq (
    .clk_i, .rst_n_i, .mem(fetch_bus.requester), .instr_o(instr), .pc_o(pc),
    .next_pc_i(next_pc), .wen_i(wen), .dren_i(dren), .dwen_i(dwen), .halt_i(dec_halt),
    .illegal_i(dec_illegal), .mem_start_o(mem_start), .mem_done_i(mem_done),
    .wb_en_o(wb_en), .retire_o, .halt_o, .illegal_o
  );

  control_unit u_ctrl (
    .instr_i(instr), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm), .alu_op_o(alu_op),
    .a_sel_o(a_sel), .b_sel_o(b_sel), .wb_sel_o(wb_sel), .wen_o(wen), .dren_o(dren),
    .dwen_o(dwen), .branch_o(branch), .jump_o(jump), .jalr_o(jalr), .halt_o(dec_halt),
    .illegal_o(dec_illegal)
  );

  exec_datapath u_dp (
    .clk_i, .rst_n_i, .pc_i(pc), .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .imm_i(imm),
    .alu_op_i(alu_op), .a_sel_i(a_sel), .b_sel_i(b_sel), .wb_sel_i(wb_sel),
    .branch_i(branch), .jump_i(jump), .jalr_i(jalr), .funct3_i(instr[14:12]),
    .load_data_i(load_data), .wb_en_i(wb_en), .next_pc_o(next_pc),
    .alu_result_o(alu_result), .store_data_o(store_data)
  );

  // Word address comes from the low bits of the ALU sum
  load_store_unit u_lsu (
    .clk_i, .rst_n_i, .start_i(mem_start), .we_i(dwen), .addr_i(addr_t'(alu_result)),
    .wdata_i(store_data), .mem(lsu_bus.requester), .done_o(mem_done),
    .load_data_o(load_data)
  );

  mem_arbiter u_arb (
    .clk_i, .rst_n_i, .fetch_port(fetch_bus.arbiter), .lsu_port(lsu_bus.arbiter),
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_rdata_i, .mem_rvalid_i
  );

endmodule

//--- src/rv32_pkg.sv
// RV32 core shared types
`include "core_cfg.svh"

package rv32_pkg;

  typedef logic [31:0]             word_t;
  typedef logic [`CORE_ADDR_W-1:0] addr_t;
  typedef logic [4:0]              reg_idx_t;

  // Base opcodes handled by the core
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    IMMED  = 7'b0010011,
    REGREG = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR
  } alu_op_t;

  typedef enum logic {A_RS1, A_PC} a_sel_t;
  typedef enum logic {B_RS2, B_IMM} b_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC_PLUS4, WB_IMM_U} wb_sel_t;

  // One instruction in flight, so the sequencer walks these in order
  typedef enum logic [2:0] {FETCH, FETCH_WAIT, EXECUTE, MEM_WAIT, STOPPED} seq_state_t;

endpackage

//--- test/core_asserts.sv
// Core protocol assertions
`timescale 1ns/1ps

module core_asserts (
  input logic clk_i,
  input logic rst_n_i,
  input logic mem_req_i,
  input logic mem_rvalid_i,
  input logic retire_i,
  input logic halt_i,
  input logic illegal_i
);

  logic outstanding_q;

  // Tracks the one request the memory still owes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (mem_req_i) begin
      outstanding_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  a_no_req_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (outstanding_q && !mem_rvalid_i) |-> !mem_req_i)
    else $error("request issued while a response is outstanding");

  a_rvalid_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rvalid_i |-> outstanding_q)
    else $error("response with no owner");

  a_stop_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(halt_i && illegal_i))
    else $error("halt and illegal both high");

  a_no_retire_stopped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (halt_i || illegal_i) |-> !retire_i)
    else $error("retire while stopped");

endmodule

bind rv32_core core_asserts u_asserts (
  .clk_i(clk_i), .rst_n_i(rst_n_i), .mem_req_i(mem_req_o), .mem_rvalid_i(mem_rvalid_i),
  .retire_i(retire_o), .halt_i(halt_o), .illegal_i(illegal_o)
);

//--- test/tb_core.sv
// RV32 core testbench
`timescale 1ns/1ps

module tb_core import rv32_pkg::*; ();

  localparam int MEM_WORDS      = 1024;
  localparam int TIMEOUT_CYCLES = 5000;

  // Base opcodes used by the program builder
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam word_t      HALT_WORD = 32'h0000006f;
  localparam word_t      ECALL     = 32'h00000073;

  logic   clk;
  logic   rst_n;
  logic   mem_req, mem_we, mem_rvalid;
  logic   retire, halt, illegal;
  addr_t  mem_addr;
  word_t  mem_wdata, mem_rdata, pend_data;
  word_t  mem [MEM_WORDS];
  word_t  prog [$];
  addr_t  exp_addr [$];
  word_t  exp_data [$];
  integer seed;
  int     store_off, n_exec, err_cnt, pend_cnt;
  int     cycle = 0;

  rv32_core dut_i (
    .clk_i(clk), .rst_n_i(rst_n), .mem_req_o(mem_req), .mem_we_o(mem_we),
    .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata),
    .mem_rvalid_i(mem_rvalid), .retire_o(retire), .halt_o(halt), .illegal_o(illegal)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // Word memory, one outstanding request, latency of 1 to 4 cycles
  initial begin
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    pend_cnt   = 0;
    forever begin
      @(posedge clk);
      #1;
      mem_rvalid = 1'b0;
      if (!rst_n) begin
        pend_cnt = 0;
      end else begin
        if (pend_cnt > 0) begin
          pend_cnt = pend_cnt - 1;
          if (pend_cnt == 0) begin
            mem_rvalid = 1'b1;
            mem_rdata  = pend_data;
          end
        end
        if (mem_req) begin
          pend_data = mem[mem_addr[11:2]];
          if (mem_we) begin
            mem[mem_addr[11:2]] = mem_wdata;
          end
          pend_cnt = 1 + ($unsigned($random(seed)) % 4);
        end
      end
    end
  end

  task automatic check(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAILED t=%0t %s: got %h, expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // Instruction encoders
  function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t enc_i(input logic [6:0] op, input logic [4:0] rd,
                                  input logic [2:0] f3, input logic [4:0] rs1,
                                  input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
                                  input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                  input logic [4:0] rs2, input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(input logic [6:0] op, input logic [4:0] rd,
                                  input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // RV32I reference results
  function automatic word_t alu_ref(input int f3, input int alt, input word_t a,
                                    input word_t b);
    word_t r;
    case (f3)
      0: r = (alt != 0) ? a - b : a + b;
      1: r = a << b[4:0];
      2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3: r = (a < b) ? 32'd1 : 32'd0;
      4: r = a ^ b;
      5: begin
        if (alt != 0) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic bit branch_ref(input int f3, input word_t a, input word_t b);
    case (f3)
      0: return a == b;
      1: return a != b;
      4: return $signed(a) < $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
    n_exec++;
  endtask

  task automatic clear_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    store_off = 0;
    n_exec    = 0;
  endtask

  // x10 points at the result area
  task automatic start_program();
    clear_program();
    emit(enc_i(OP_IMM, 10, 3'b000, 0, 32'h400));
  endtask

  task automatic store_expect(input logic [4:0] rs, input word_t value);
    emit(enc_s(10, rs, store_off));
    exp_addr.push_back(addr_t'(32'h400 + store_off));
    exp_data.push_back(value);
    store_off += 4;
  endtask

  task automatic finish_program();
    prog.push_back(HALT_WORD);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {16'h5a5a, 16'(i * 4)};
    end
    foreach (prog[i]) begin
      mem[i] = prog[i];
    end
  endtask

  task automatic timeout_fail(input string name);
    $display("Timeout in %s: the core never stopped", name);
    $display("FAIL: see errors above");
    $fatal(1, "timeout");
  endtask

  // Reset, run to halt or illegal, then check retirement, status and stores
  task automatic run_program(input string name, input logic exp_illegal);
    int retires, waited, last_retire, stop_cycle, late;
    retires     = 0;
    waited      = 0;
    late        = 0;
    last_retire = -1;
    @(posedge clk);
    #1 rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    while (!(halt || illegal)) begin
      @(negedge clk);
      if (retire) begin
        retires++;
        last_retire = cycle;
      end
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        timeout_fail(name);
      end
    end
    stop_cycle = cycle;
    repeat (8) begin
      @(negedge clk);
      if (retire) late++;
    end
    check({name, " retire count"}, retires, n_exec);
    check({name, " retire after stop"}, late, 0);
    check({name, " retire before stop"}, last_retire < stop_cycle, 1);
    check({name, " halt_o"}, halt, !exp_illegal);
    check({name, " illegal_o"}, illegal, exp_illegal);
    foreach (exp_addr[i]) begin
      check($sformatf("%s mem[%h]", name, exp_addr[i]), mem[exp_addr[i][11:2]], exp_data[i]);
    end
  endtask

  task automatic test_arith();
    word_t a, b, imm, pc;
    start_program();
    a = 32'h12345678;
    b = 32'hfffffff9;
    emit(enc_u(OP_LUI, 1, 20'h12345));
    emit(enc_i(OP_IMM, 1, 3'b000, 1, 32'h678));
    emit(enc_i(OP_IMM, 2, 3'b000, 0, 32'hff9));
    store_expect(1, a);
    store_expect(2, b);
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f3 == 0 || f3 == 5) begin
          emit(enc_r((alt != 0) ? 7'b0100000 : 7'b0, 2, 1, f3, 4));
          store_expect(4, alu_ref(f3, alt, a, b));
        end
        // Immediate forms, no SUBI
        if ((alt == 0 && f3 != 5) || f3 == 5) begin
          if (f3 == 1 || f3 == 5) begin
            imm = (alt != 0) ? 32'h403 : 32'h3;
          end else begin
            imm = 32'hfffff8f3;
          end
          emit(enc_i(OP_IMM, 5, f3, 1, imm));
          store_expect(5, alu_ref(f3, alt, a, imm));
        end
      end
    end
    pc = prog.size() * 4;
    emit(enc_u(OP_AUIPC, 6, 20'h00321));
    store_expect(6, pc + 32'h00321000);
    finish_program();
    run_program("arith", 1'b0);
  endtask

  task automatic test_load_store();
    word_t d0, d1;
    d0 = 32'h0badf00d;
    d1 = 32'h13572468;
    start_program();
    emit(enc_i(OP_LOAD, 5, 3'b010, 10, 32'h100));
    emit(enc_i(OP_LOAD, 6, 3'b010, 10, 32'h104));
    emit(enc_r(7'b0, 6, 5, 3'b000, 7));
    store_expect(7, d0 + d1);
    emit(enc_i(OP_IMM, 8, 3'b100, 5, 32'h0ff));
    store_expect(8, d0 ^ 32'h0ff);
    // Write to x0 is dropped
    emit(enc_i(OP_IMM, 0, 3'b000, 5, 32'h055));
    store_expect(0, 32'h0);
    emit(enc_s(10, 7, 32'h104));
    emit(enc_i(OP_LOAD, 9, 3'b010, 10, 32'h104));
    store_expect(9, d0 + d1);
    exp_addr.push_back(addr_t'(16'h0504));
    exp_data.push_back(d0 + d1);
    finish_program();
    mem[16'h0500 >> 2] = d0;
    mem[16'h0504 >> 2] = d1;
    run_program("load store", 1'b0);
  endtask

  task automatic test_control_flow();
    int    br_f3 [6] = '{0, 1, 4, 5, 6, 7};
    word_t pc;
    bit    taken;
    start_program();
    emit(enc_i(OP_IMM, 3, 3'b000, 0, 32'hfff));
    emit(enc_i(OP_IMM, 4, 3'b000, 0, 32'h001));
    emit(enc_i(OP_IMM, 11, 3'b000, 10, 32'h200));
    emit(enc_i(OP_IMM, 2, 3'b000, 0, 32'h003));
    // Counting loop, body runs three times
    emit(enc_i(OP_IMM, 1, 3'b000, 1, 32'h001));
    emit(enc_s(11, 1, 32'h0));
    emit(enc_i(OP_IMM, 11, 3'b000, 11, 32'h004));
    emit(enc_b(3'b100, 1, 2, -12));
    n_exec += 8;
    for (int k = 1; k <= 3; k++) begin
      exp_addr.push_back(addr_t'(32'h600 + 4 * (k - 1)));
      exp_data.push_back(word_t'(k));
    end
    // Each branch with x3 = -1 and x4 = 1 in both orders
    foreach (br_f3[i]) begin
      for (int swap = 0; swap < 2; swap++) begin
        taken = (swap != 0) ? branch_ref(br_f3[i], 32'h1, 32'hffffffff) :
                              branch_ref(br_f3[i], 32'hffffffff, 32'h1);
        emit(enc_i(OP_IMM, 5, 3'b000, 0, 32'h0aa));
        emit(enc_b(br_f3[i], (swap != 0) ? 4 : 3, (swap != 0) ? 3 : 4, 8));
        emit(enc_i(OP_IMM, 5, 3'b000, 0, 32'h055));
        if (taken) n_exec--;
        store_expect(5, taken ? 32'h0aa : 32'h055);
      end
    end
    pc = prog.size() * 4;
    emit(enc_j(7, 8));
    emit(enc_i(OP_IMM, 6, 3'b000, 0, 32'h063));
    n_exec--;
    store_expect(7, pc + 4);
    // Odd JALR offset, target low bit must clear
    pc = prog.size() * 4;
    emit(enc_u(OP_AUIPC, 8, 20'h0));
    emit(enc_i(OP_JALR, 9, 3'b000, 8, 32'd13));
    emit(enc_i(OP_IMM, 6, 3'b000, 0, 32'h04d));
    n_exec--;
    // PC at the landing point, even if the JALR sum was odd
    emit(enc_u(OP_AUIPC, 12, 20'h0));
    store_expect(12, pc + 12);
    store_expect(9, pc + 8);
    store_expect(6, 32'h0);
    finish_program();
    run_program("control flow", 1'b0);
  endtask

  task automatic test_illegal();
    clear_program();
    emit(enc_i(OP_IMM, 5, 3'b000, 0, 32'd42));
    emit(enc_s(0, 5, 32'h400));
    prog.push_back(ECALL);
    prog.push_back(enc_s(0, 5, 32'h404));
    exp_addr.push_back(addr_t'(16'h0400));
    exp_data.push_back(32'd42);
    exp_addr.push_back(addr_t'(16'h0404));
    exp_data.push_back(32'h5a5a0404);
    finish_program();
    run_program("illegal", 1'b1);
  endtask

  initial begin
    seed    = 32'hb47ae330;
    rst_n   = 1'b0;
    err_cnt = 0;
    test_arith();
    test_load_store();
    test_control_flow();
    test_illegal();
    if (err_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "errors were found");
    end
  end

endmodule
